/* build.f */
+incdir+verilog
verilog/drawPkg.sv
verilog/drawScheduler.sv
verilog/cmdDecoder.sv
verilog/rectFiller.sv
verilog/sdramBurstWriter.sv
verilog/drawAdapter.sv
testbench/drawAdapter_properties.sv
testbench/drawAdapter_tb.sv

/* testbench/drawAdapter_tb.sv */
`timescale 1ns/1ns
`include "draw_macros.svh"

module drawAdapter_tb;

    localparam int BURSTS_PER_ROW = `SCREEN_W / `BURST_PIX;
    localparam int CLEAR_BURSTS   = BURSTS_PER_ROW * `SCREEN_H; // Whole screen.
    localparam int HEAD_BURSTS    = BURSTS_PER_ROW * 2;          // Rows 0 and 1.
    localparam int FB_SIZE        = `SCREEN_W * `SCREEN_H;
    localparam int PASS_LIMIT     = 1500; // Cycles allowed per loop pass.

    logic        clk = 1'b0;
    logic        rst_n;
    logic        en;
    logic [31:0] pulseCounter;
    logic [31:0] accumCounter;
    logic        dataUpdate;
    logic [7:0]  gainDivider;
    logic [7:0]  intervalSel;
    logic [15:0] maxPulse;
    logic [15:0] minPulse;
    logic [23:0] sdramWrAddr;
    logic [15:0] sdramWrData1;
    logic [15:0] sdramWrData2;
    logic [15:0] sdramWrData3;
    logic [15:0] sdramWrData4;
    logic        sdramWrReq;
    logic        sdramWrDone = 1'b0;
    logic        led;

    logic [39:0] expQ[$];        // Expected bursts, {address, colour}.
    logic [15:0] fb[0:FB_SIZE-1]; // Frame buffer of the SDRAM model.
    logic [31:0] modelLatch;     // Model of the scheduler's pulse latch.
    int          burstCount = 0;
    int          doneWait = 0;
    bit          pending = 1'b0;
    bit          hung = 1'b0;    // A wait ran out, remaining steps skipped.
    int          burstErrs = 0;
    int          frameErrs = 0;
    int          seqErrs = 0;
    int unsigned seedDummy;
    int          totalErrs;

    always #4 clk = ~clk; // 8 ns period.

    drawAdapter UUT (
        .clk(clk), .rst_n(rst_n), .en(en),
        .pulseCounter(pulseCounter), .accumCounter(accumCounter),
        .dataUpdate(dataUpdate), .gainDivider(gainDivider),
        .intervalSel(intervalSel), .maxPulse(maxPulse), .minPulse(minPulse),
        .sdramWrAddr(sdramWrAddr), .sdramWrData1(sdramWrData1),
        .sdramWrData2(sdramWrData2), .sdramWrData3(sdramWrData3),
        .sdramWrData4(sdramWrData4), .sdramWrReq(sdramWrReq),
        .sdramWrDone(sdramWrDone), .led(led)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Expected-burst model.
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [15:0] paletteColor(input int idx);
        case (idx)
            0:       return `COLOR_GAIN0;
            1:       return `COLOR_GAIN1;
            2:       return `COLOR_GAIN2;
            default: return `COLOR_GAIN3;
        endcase
    endfunction

    // Raster order, widths in bursts.
    task automatic pushRect(input int x0, input int w, input int y0, input int h,
                            input logic [15:0] c);
        int r;
        int b;
        for (r = y0; r < y0 + h; r++) begin
            for (b = x0; b < x0 + w; b++)
                expQ.push_back({24'(r * `SCREEN_W + b * `BURST_PIX), c});
        end
    endtask

    // One loop pass from the inputs now on the pins.
    task automatic pushPass();
        int maxB;
        int minB;
        int lo;
        int hi;
        pushRect(0, 1 + int'(modelLatch % 8), 4, 2, `COLOR_PULSE);
        if (dataUpdate)
            modelLatch = pulseCounter; // Takes effect from the next PULSE on.
        pushRect(0, 1 + int'(accumCounter % 8), 7, 2, `COLOR_ACCUM);
        pushRect(0, 1 + int'(gainDivider % 4), 10, 1, paletteColor(int'(intervalSel % 4)));
        maxB = int'(maxPulse % 8);
        minB = int'(minPulse % 8);
        lo   = (maxB < minB) ? maxB : minB; // Min/max swap.
        hi   = (maxB < minB) ? minB : maxB;
        pushRect(lo, hi - lo + 1, 12, 2, `COLOR_RANGE);
    endtask

    task automatic randomInputs();
        pulseCounter = $urandom;
        accumCounter = $urandom;
        gainDivider  = 8'($urandom);
        intervalSel  = 8'($urandom);
        maxPulse     = 16'($urandom);
        minPulse     = 16'($urandom);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // SDRAM model, answers each request after 0 to 5 cycles.
    ////////////////////////////////////////////////////////////////////////////
    task automatic checkBurst();
        logic [39:0] want;
        string       name;
        name = (burstCount < CLEAR_BURSTS + HEAD_BURSTS) ? "clearHeader" : "statusBars";
        if (expQ.size() == 0) begin
            seqErrs++;
            $display("Unexpected SDRAM write at address %0d, no burst was left to expect",
                     sdramWrAddr);
        end else begin
            want = expQ.pop_front();
            if (sdramWrAddr !== want[39:16]) begin
                burstErrs++;
                $display("ERR %s burst %0d address: expected %0d actual %0d",
                         name, burstCount, want[39:16], sdramWrAddr);
            end
            if ({sdramWrData1, sdramWrData2, sdramWrData3, sdramWrData4} !==
                {4{want[15:0]}}) begin
                burstErrs++;
                $display("ERR %s burst %0d data: expected %h actual %h %h %h %h",
                         name, burstCount, want[15:0], sdramWrData1, sdramWrData2,
                         sdramWrData3, sdramWrData4);
            end
        end
        if (sdramWrAddr + 3 < FB_SIZE) begin
            fb[sdramWrAddr]     = sdramWrData1;
            fb[sdramWrAddr + 1] = sdramWrData2;
            fb[sdramWrAddr + 2] = sdramWrData3;
            fb[sdramWrAddr + 3] = sdramWrData4;
        end else begin
            seqErrs++;
            $display("SDRAM write at address %0d falls outside the frame buffer",
                     sdramWrAddr);
        end
        burstCount++;
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            sdramWrDone = 1'b0;
            pending     = 1'b0;
        end else if (sdramWrDone) begin
            sdramWrDone = 1'b0; // One-cycle pulse.
        end else if (pending) begin
            doneWait--;
            if (doneWait == 0) begin
                sdramWrDone = 1'b1;
                pending     = 1'b0;
            end
        end else if (sdramWrReq) begin
            checkBurst(); // New request.
            doneWait = $urandom % 6;
            if (doneWait == 0)
                sdramWrDone = 1'b1;
            else
                pending = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Waits and checks.
    ////////////////////////////////////////////////////////////////////////////
    task automatic waitBursts(input int n);
        int cnt;
        cnt = 0;
        if (hung)
            return;
        while (burstCount < n && cnt < 3000) begin
            @(posedge clk);
            cnt++;
        end
        if (burstCount < n) begin
            hung = 1'b1;
            seqErrs++;
            $display("Timed out waiting for clear and header, only %0d bursts seen",
                     burstCount);
        end
    endtask

    task automatic waitLedToggle(input int pass);
        int   cnt;
        logic prev;
        cnt = 0;
        if (hung)
            return;
        @(negedge clk);
        prev = led;
        while (led === prev && cnt < PASS_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (led === prev) begin
            hung = 1'b1;
            seqErrs++;
            $display("Timed out waiting for the led to toggle in pass %0d", pass);
        end
    endtask

    // Whole screen after clear and header.
    task automatic checkFrame();
        int          p;
        logic [15:0] want;
        for (p = 0; p < FB_SIZE; p++) begin
            want = (p / `SCREEN_W < 2) ? `COLOR_HEADER : `COLOR_BG;
            if (fb[p] !== want) begin
                frameErrs++;
                $display("ERR frameBuffer pixel %0d: expected %h actual %h", p, want, fb[p]);
            end
        end
    endtask

    task automatic runSequence(input string name, input int passes);
        int cnt;
        int k;
        if (hung)
            return;
        expQ.delete();
        burstCount = 0;
        modelLatch = '0; // Latch emptied while en was low.
        randomInputs();
        dataUpdate = 1'b0;
        pushRect(0, BURSTS_PER_ROW, 0, `SCREEN_H, `COLOR_BG);
        pushRect(0, BURSTS_PER_ROW, 0, 2, `COLOR_HEADER);
        pushPass();
        @(negedge clk);
        en = 1'b1;
        for (cnt = 1; cnt <= `POWERUP_CYCLES; cnt++) begin
            @(negedge clk);
            if (sdramWrReq) begin
                seqErrs++;
                $display("ERR %s cycle %0d sdramWrReq: expected 0 actual 1", name, cnt);
            end
        end
        waitBursts(CLEAR_BURSTS + HEAD_BURSTS);
        if (hung)
            return;
        checkFrame();
        for (k = 1; k <= passes; k++) begin
            waitLedToggle(k);
            if (hung)
                return;
            // Toggle only after RANGE, so every burst of the pass is in.
            if (expQ.size() != 0) begin
                seqErrs++;
                $display("ERR %s pass %0d pending bursts: expected 0 actual %0d",
                         name, k, expQ.size());
            end
            if (k < passes) begin
                randomInputs();
                dataUpdate = ($urandom % 3 == 0);
                pushPass();
                @(negedge clk);
                dataUpdate = 1'b0;
            end else begin
                en = 1'b0; // Before the next PULSE is issued.
            end
        end
    endtask

    task automatic holdDisabled();
        int cnt;
        int n;
        cnt = 0;
        if (hung)
            return;
        while (sdramWrReq && cnt < 100) begin
            @(negedge clk);
            cnt++;
        end
        if (sdramWrReq) begin
            hung = 1'b1;
            seqErrs++;
            $display("Timed out waiting for the SDRAM request to complete");
            return;
        end
        n = 8 + $urandom % 5; // Longer than a command takes to reach the SDRAM port.
        repeat (n) begin
            @(negedge clk);
            if (sdramWrReq || led) begin
                seqErrs++;
                $display("ERR disabled req/led: expected 0/0 actual %0d/%0d",
                         sdramWrReq, led);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        rst_n        = 1'b0;
        en           = 1'b0;
        pulseCounter = '0;
        accumCounter = '0;
        dataUpdate   = 1'b0;
        gainDivider  = '0;
        intervalSel  = '0;
        maxPulse     = '0;
        minPulse     = '0;
        seedDummy    = $urandom(49273);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (sdramWrReq !== 1'b0 || led !== 1'b0) begin
            seqErrs++;
            $display("ERR reset req/led: expected 0/0 actual %b/%b", sdramWrReq, led);
        end
        runSequence("powerup", 6);
        holdDisabled();
        runSequence("enable", 3); // Restart after en was dropped.
        holdDisabled();           // Odd pass count leaves led high before the drop.
        totalErrs = burstErrs + frameErrs + seqErrs + UUT.uProps.failCount;
        $display("Errors: burst %0d, frame %0d, sequence %0d, assertion %0d",
                 burstErrs, frameErrs, seqErrs, UUT.uProps.failCount);
        if (totalErrs == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* testbench/drawAdapter_properties.sv */
`timescale 1ns/1ns

module drawAdapter_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        sdramWrReq,
    input logic        sdramWrDone,
    input logic [23:0] sdramWrAddr,
    input logic [15:0] sdramWrData1,
    input logic [15:0] sdramWrData2,
    input logic [15:0] sdramWrData3,
    input logic [15:0] sdramWrData4,
    input logic        burstStrobe,
    input logic        writerBusy,
    input logic        cmdStart,
    input logic        drawDone
);
    int   failCount = 0; // Read by the testbench at the end.
    logic outstanding;   // Command issued, drawDone not yet seen.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            outstanding <= 1'b0;
        else if (cmdStart)
            outstanding <= 1'b1;
        else if (drawDone)
            outstanding <= 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory port and internal handshakes.
    ////////////////////////////////////////////////////////////////////////////
    reqStable: assert property (@(posedge clk) disable iff (!rst_n)
        (sdramWrReq && !sdramWrDone) |=> sdramWrReq && $stable(sdramWrAddr) &&
            $stable({sdramWrData1, sdramWrData2, sdramWrData3, sdramWrData4}))
        else begin
            failCount++;
            $error("SDRAM request dropped or payload changed before done");
        end

    strobeIdle: assert property (@(posedge clk) disable iff (!rst_n)
        !(burstStrobe && writerBusy))
        else begin
            failCount++;
            $error("Burst strobe while the writer is busy");
        end

    cmdSingle: assert property (@(posedge clk) disable iff (!rst_n)
        cmdStart |-> !outstanding)
        else begin
            failCount++;
            $error("New command issued before drawDone of the previous one");
        end

endmodule

bind drawAdapter drawAdapter_properties uProps (
    .clk(clk), .rst_n(rst_n), .sdramWrReq(sdramWrReq), .sdramWrDone(sdramWrDone),
    .sdramWrAddr(sdramWrAddr), .sdramWrData1(sdramWrData1),
    .sdramWrData2(sdramWrData2), .sdramWrData3(sdramWrData3),
    .sdramWrData4(sdramWrData4), .burstStrobe(burstStrobe),
    .writerBusy(writerBusy), .cmdStart(cmdStart), .drawDone(drawDone)
);

/* verilog/drawAdapter.sv */
`timescale 1ns/1ns

module drawAdapter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic [31:0] pulseCounter,
    input  logic [31:0] accumCounter,
    input  logic        dataUpdate,
    input  logic [7:0]  gainDivider,
    input  logic [7:0]  intervalSel,
    input  logic [15:0] maxPulse,
    input  logic [15:0] minPulse,
    output logic [23:0] sdramWrAddr,
    output logic [15:0] sdramWrData1,
    output logic [15:0] sdramWrData2,
    output logic [15:0] sdramWrData3,
    output logic [15:0] sdramWrData4,
    output logic        sdramWrReq,
    input  logic        sdramWrDone,
    output logic        led
);
    import drawPkg::*;

    // Scheduler to decoder.
    logic        cmdStart;
    drawCmd      cmd;
    logic [31:0] data1;
    logic [31:0] data2;
    // Decoder to filler.
    logic        fillStart;
    logic [2:0]  x0Burst;
    logic [2:0]  widthBursts;
    logic [3:0]  y0;
    logic [3:0]  height;
    logic [15:0] color;
    // Filler to writer, and back.
    logic        burstStrobe;
    logic [23:0] burstAddr;
    logic [15:0] burstColor;
    logic        writerBusy;
    logic        drawDone;

    drawScheduler uScheduler (
        .clk(clk), .rst_n(rst_n), .en(en),
        .pulseCounter(pulseCounter), .accumCounter(accumCounter),
        .dataUpdate(dataUpdate), .gainDivider(gainDivider),
        .intervalSel(intervalSel), .maxPulse(maxPulse), .minPulse(minPulse),
        .drawDone(drawDone), .cmdStart(cmdStart), .cmd(cmd),
        .data1(data1), .data2(data2), .led(led)
    );

    cmdDecoder uDecoder (
        .clk(clk), .rst_n(rst_n), .cmdStart(cmdStart), .cmd(cmd),
        .data1(data1), .data2(data2), .fillStart(fillStart),
        .x0Burst(x0Burst), .widthBursts(widthBursts),
        .y0(y0), .height(height), .color(color)
    );

    rectFiller uFiller (
        .clk(clk), .rst_n(rst_n), .fillStart(fillStart),
        .x0Burst(x0Burst), .widthBursts(widthBursts), .y0(y0), .height(height),
        .color(color), .writerBusy(writerBusy), .burstStrobe(burstStrobe),
        .burstAddr(burstAddr), .burstColor(burstColor), .drawDone(drawDone)
    );

    sdramBurstWriter uWriter (
        .clk(clk), .rst_n(rst_n), .burstStrobe(burstStrobe),
        .burstAddr(burstAddr), .burstColor(burstColor), .writerBusy(writerBusy),
        .sdramWrAddr(sdramWrAddr), .sdramWrData1(sdramWrData1),
        .sdramWrData2(sdramWrData2), .sdramWrData3(sdramWrData3),
        .sdramWrData4(sdramWrData4), .sdramWrReq(sdramWrReq),
        .sdramWrDone(sdramWrDone)
    );

endmodule

/* verilog/sdramBurstWriter.sv */
`timescale 1ns/1ns

module sdramBurstWriter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        burstStrobe,
    input  logic [23:0] burstAddr,
    input  logic [15:0] burstColor,
    output logic        writerBusy,
    output logic [23:0] sdramWrAddr,
    output logic [15:0] sdramWrData1,
    output logic [15:0] sdramWrData2,
    output logic [15:0] sdramWrData3,
    output logic [15:0] sdramWrData4,
    output logic        sdramWrReq,
    input  logic        sdramWrDone
);
    logic        reqActive; // Burst held on the memory port.
    logic [15:0] colorHold; // Single colour for all four pixels.

    ////////////////////////////////////////////////////////////////////////////
    // Request level.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reqActive <= 1'b0;
        end else if (burstStrobe) begin
            reqActive <= 1'b1; // Rises the cycle after the strobe.
        end else if (reqActive && sdramWrDone) begin
            reqActive <= 1'b0; // Drops the cycle after done.
        end
    end

    // Burst payload, only loaded while idle so it stays put under request.
    always_ff @(posedge clk) begin
        if (burstStrobe) begin
            sdramWrAddr <= burstAddr;
            colorHold   <= burstColor;
        end
    end

    // Busy and request are one level seen from two sides.
    assign writerBusy = reqActive;
    assign sdramWrReq = reqActive;

    // Rectangle fill, every pixel same colour.
    assign sdramWrData1 = colorHold;
    assign sdramWrData2 = colorHold;
    assign sdramWrData3 = colorHold;
    assign sdramWrData4 = colorHold;

endmodule

/* verilog/rectFiller.sv */
`timescale 1ns/1ns
`include "draw_macros.svh"

module rectFiller (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fillStart,
    input  logic [2:0]  x0Burst,
    input  logic [2:0]  widthBursts, // Last burst offset in a row.
    input  logic [3:0]  y0,
    input  logic [3:0]  height,      // Last row offset.
    input  logic [15:0] color,
    input  logic        writerBusy,
    output logic        burstStrobe,
    output logic [23:0] burstAddr,
    output logic [15:0] burstColor,
    output logic        drawDone
);
    localparam logic [23:0] ROW_PITCH  = 24'(`SCREEN_W);  // Pixels per row.
    localparam logic [23:0] BURST_STEP = 24'(`BURST_PIX); // Pixels per burst.

    logic       active;   // Rectangle in progress.
    logic       lastSent; // Final burst already strobed.
    logic [2:0] xCnt;
    logic [3:0] yCnt;
    logic [2:0] curCol;
    logic [3:0] curRow;
    logic       issue;

    assign curCol = x0Burst + xCnt;
    assign curRow = y0 + yCnt;

    // Writer busy shows one cycle after a strobe, so the strobe itself blocks too.
    assign issue = active && !lastSent && !burstStrobe && !writerBusy;

    ////////////////////////////////////////////////////////////////////////////
    // Raster walk.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active      <= 1'b0;
            lastSent    <= 1'b0;
            xCnt        <= '0;
            yCnt        <= '0;
            burstStrobe <= 1'b0;
            drawDone    <= 1'b0;
        end else begin
            burstStrobe <= issue;
            drawDone    <= 1'b0;
            if (fillStart) begin
                active   <= 1'b1;
                lastSent <= 1'b0;
                xCnt     <= '0;
                yCnt     <= '0;
            end else if (issue) begin
                if (xCnt == widthBursts) begin // End of row.
                    xCnt <= '0;
                    if (yCnt == height)
                        lastSent <= 1'b1;
                    else
                        yCnt <= yCnt + 1'b1;
                end else begin
                    xCnt <= xCnt + 1'b1;
                end
            end else if (active && lastSent && !burstStrobe && !writerBusy) begin
                active   <= 1'b0; // Last burst written.
                lastSent <= 1'b0;
                drawDone <= 1'b1;
            end
        end
    end

    // Linear pixel index of the burst's first pixel.
    always_ff @(posedge clk) begin
        if (issue) begin
            burstAddr  <= 24'(curRow) * ROW_PITCH + 24'(curCol) * BURST_STEP;
            burstColor <= color;
        end
    end

endmodule

/* verilog/cmdDecoder.sv */
`timescale 1ns/1ns
`include "draw_macros.svh"

// Widths and heights leave as last index (count minus one).
module cmdDecoder (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmdStart,
    input  drawPkg::drawCmd cmd,
    input  logic [31:0]     data1,
    input  logic [31:0]     data2,
    output logic            fillStart,
    output logic [2:0]      x0Burst,
    output logic [2:0]      widthBursts,
    output logic [3:0]      y0,
    output logic [3:0]      height,
    output logic [15:0]     color
);
    import drawPkg::*;

    localparam logic [2:0] LAST_BURST = 3'(`SCREEN_W / `BURST_PIX - 1);
    localparam logic [3:0] LAST_ROW   = 4'(`SCREEN_H - 1);

    logic [2:0]  nextX0;
    logic [2:0]  nextW;
    logic [3:0]  nextY0;
    logic [3:0]  nextH;
    logic [15:0] nextColor;
    logic [2:0]  maxB;      // Range end candidates in bursts.
    logic [2:0]  minB;
    logic [15:0] gainColor;

    assign maxB = data1[2:0]; // Modulo 8.
    assign minB = data2[2:0];

    // Gain palette lookup.
    always_comb begin
        case (data2[1:0])
            2'd0:    gainColor = `COLOR_GAIN0;
            2'd1:    gainColor = `COLOR_GAIN1;
            2'd2:    gainColor = `COLOR_GAIN2;
            default: gainColor = `COLOR_GAIN3;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Rectangle rules per command.
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        nextX0    = 3'd0;
        nextW     = LAST_BURST;   // Full width by default.
        nextY0    = 4'd0;
        nextH     = LAST_ROW;
        nextColor = `COLOR_BG;
        case (cmd)
            CMD_HEADER: begin
                nextH     = 4'd1;         // Rows 0 and 1.
                nextColor = `COLOR_HEADER;
            end
            CMD_PULSE: begin
                nextW     = data1[2:0];   // 1 + data1 mod 8 bursts.
                nextY0    = 4'd4;
                nextH     = 4'd1;
                nextColor = `COLOR_PULSE;
            end
            CMD_ACCUM: begin
                nextW     = data1[2:0];
                nextY0    = 4'd7;
                nextH     = 4'd1;
                nextColor = `COLOR_ACCUM;
            end
            CMD_SETTINGS: begin
                nextW     = {1'b0, data1[1:0]}; // 1 + data1 mod 4 bursts.
                nextY0    = 4'd10;
                nextH     = 4'd0;               // Single row.
                nextColor = gainColor;
            end
            CMD_RANGE: begin
                // Span from the smaller end to the larger, inclusive.
                nextX0    = (maxB >= minB) ? minB : maxB;
                nextW     = (maxB >= minB) ? (maxB - minB) : (minB - maxB);
                nextY0    = 4'd12;
                nextH     = 4'd1;
                nextColor = `COLOR_RANGE;
            end
            default: ; // CLEAR keeps the whole-screen defaults.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            fillStart <= 1'b0;
        else
            fillStart <= cmdStart; // One cycle behind cmdStart.
    end

    // Rectangle held until the next command.
    always_ff @(posedge clk) begin
        if (cmdStart) begin
            x0Burst     <= nextX0;
            widthBursts <= nextW;
            y0          <= nextY0;
            height      <= nextH;
            color       <= nextColor;
        end
    end

endmodule

/* verilog/drawScheduler.sv */
`timescale 1ns/1ns
`include "draw_macros.svh"

module drawScheduler (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  logic [31:0]     pulseCounter,
    input  logic [31:0]     accumCounter,
    input  logic            dataUpdate,
    input  logic [7:0]      gainDivider,
    input  logic [7:0]      intervalSel,
    input  logic [15:0]     maxPulse,
    input  logic [15:0]     minPulse,
    input  logic            drawDone,
    output logic            cmdStart,
    output drawPkg::drawCmd cmd,
    output logic [31:0]     data1,
    output logic [31:0]     data2,
    output logic            led
);
    import drawPkg::*;

    localparam int PU_W = $clog2(`POWERUP_CYCLES + 1);
    localparam logic [PU_W-1:0] PU_LAST = PU_W'(`POWERUP_CYCLES - 1);

    schedState       state;
    logic [PU_W-1:0] powerCnt;   // Power-up delay counter.
    logic            busyCmd;    // A command is out and its drawDone not yet seen.
    logic [31:0]     pulseLatch; // Pulse count from the last dataUpdate.
    logic            issueNow;

    // Issue once per command step, only with nothing outstanding.
    assign issueNow = en && !busyCmd &&
                      (state inside {ST_CLEAR, ST_HEADER, ST_PULSE,
                                     ST_ACCUM, ST_SETTINGS, ST_RANGE});

    // Pulse count latch, emptied while disabled.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pulseLatch <= '0;
        end else if (!en) begin
            pulseLatch <= '0;
        end else if (dataUpdate) begin
            pulseLatch <= pulseCounter;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Step sequencing.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            powerCnt <= '0;
            busyCmd  <= 1'b0;
            cmdStart <= 1'b0;
            led      <= 1'b0;
        end else begin
            cmdStart <= issueNow; // One-cycle strobe.
            // Outstanding flag survives en low so a late drawDone is absorbed.
            if (drawDone)
                busyCmd <= 1'b0;
            else if (issueNow)
                busyCmd <= 1'b1;
            if (!en) begin
                state    <= ST_IDLE;
                powerCnt <= '0;
                led      <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (!busyCmd) begin // Old command drained first.
                            state    <= ST_POWERUP;
                            powerCnt <= '0;
                        end
                    end
                    ST_POWERUP: begin
                        if (powerCnt == PU_LAST)
                            state <= ST_CLEAR;
                        else
                            powerCnt <= powerCnt + 1'b1;
                    end
                    ST_CLEAR:    if (busyCmd && drawDone) state <= ST_HEADER;
                    ST_HEADER:   if (busyCmd && drawDone) state <= ST_PULSE;
                    ST_PULSE:    if (busyCmd && drawDone) state <= ST_ACCUM;
                    ST_ACCUM:    if (busyCmd && drawDone) state <= ST_SETTINGS;
                    ST_SETTINGS: if (busyCmd && drawDone) state <= ST_RANGE;
                    ST_RANGE: begin
                        if (busyCmd && drawDone) begin
                            state <= ST_PULSE; // Loop again.
                            led   <= ~led;     // One toggle per pass.
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // Command and data, sampled in the issue cycle.
    always_ff @(posedge clk) begin
        if (issueNow) begin
            case (state)
                ST_CLEAR: begin
                    cmd   <= CMD_CLEAR;
                    data1 <= '0;
                    data2 <= '0;
                end
                ST_HEADER: begin
                    cmd   <= CMD_HEADER;
                    data1 <= '0;
                    data2 <= '0;
                end
                ST_PULSE: begin
                    cmd   <= CMD_PULSE;
                    data1 <= pulseLatch; // Latched count, not the live one.
                    data2 <= '0;
                end
                ST_ACCUM: begin
                    cmd   <= CMD_ACCUM;
                    data1 <= accumCounter;
                    data2 <= '0;
                end
                ST_SETTINGS: begin
                    cmd   <= CMD_SETTINGS;
                    data1 <= {24'd0, gainDivider};
                    data2 <= {24'd0, intervalSel};
                end
                default: begin
                    cmd   <= CMD_RANGE;
                    data1 <= {16'd0, maxPulse};
                    data2 <= {16'd0, minPulse};
                end
            endcase
        end
    end

endmodule

/* verilog/drawPkg.sv */
package drawPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Drawing commands, from scheduler to decoder.
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        CMD_CLEAR    = 3'd0, // Whole screen in background colour.
        CMD_HEADER   = 3'd1, // Fixed header band.
        CMD_PULSE    = 3'd2, // Latest pulse count bar.
        CMD_ACCUM    = 3'd3, // Accumulated count bar.
        CMD_SETTINGS = 3'd4, // Gain and interval bar.
        CMD_RANGE    = 3'd5  // Max/min range bar.
    } drawCmd;

    ////////////////////////////////////////////////////////////////////////////
    // Scheduler steps.
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0, // Disabled.
        ST_POWERUP  = 3'd1, // Counting the power-up delay.
        ST_CLEAR    = 3'd2,
        ST_HEADER   = 3'd3,
        ST_PULSE    = 3'd4, // Start of the redraw loop.
        ST_ACCUM    = 3'd5,
        ST_SETTINGS = 3'd6,
        ST_RANGE    = 3'd7  // End of the redraw loop.
    } schedState;

endpackage

/* verilog/draw_macros.svh */
`ifndef DRAW_MACROS_SVH
`define DRAW_MACROS_SVH

// Shrunk screen geometry for simulation.
`define SCREEN_W        32
`define SCREEN_H        16

// Pixels written per SDRAM burst.
`define BURST_PIX       4

// Clock cycles to wait after en rises.
`define POWERUP_CYCLES  20

// RGB565 colours of the fixed screen parts.
`define COLOR_BG        16'h1986
`define COLOR_HEADER    16'hFFE0
`define COLOR_PULSE     16'h07E0
`define COLOR_ACCUM     16'h001F
`define COLOR_RANGE     16'hF800

// Gain palette, indexed by the setting bar data.
`define COLOR_GAIN0     16'hF81F
`define COLOR_GAIN1     16'h07FF
`define COLOR_GAIN2     16'hFD20
`define COLOR_GAIN3     16'hFFFF

`endif
